// File: esp_link.f
rtl/esp_link_pkg.sv
rtl/spi_byte_slave.sv
rtl/cmd_parser.sv
rtl/host_regs.sv
rtl/flash_spi_master.sv
rtl/esp_link_top.sv
verif/esp_link_tb.sv

// File: rtl/cmd_parser.sv
module cmd_parser (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      byte_valid,
  input  byte                       rx_byte,
  output esp_link_pkg::cmd_action_t action,
  output logic                      cmd_unknown
);

  import esp_link_pkg::*;

  typedef enum logic {
    idle,
    read_params
  } state_e;

  state_e     state;
  logic [1:0] n_params;
  logic [1:0] idx;

  // lookup for the incoming command byte
  logic       lut_known;
  logic [1:0] lut_params;

  always_comb begin
    lut_known  = 1'b1;
    lut_params = 2'd0;
    case (cmd_e'(rx_byte))
      get_cookie,
      get_version,
      get_spi_data,
      ptrs_rst,
      z80_pause,
      z80_resume: lut_params = 2'd0;
      set_led,
      set_esp_status,
      set_spi_ctrl_reg,
      set_spi_data: lut_params = 2'd1;
      set_screen_color: lut_params = 2'd3;
      default: lut_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state       <= idle;
      n_params    <= 2'd0;
      idx         <= 2'd0;
      action      <= '0;
      cmd_unknown <= 1'b0;
    end else begin
      action.valid <= 1'b0;
      cmd_unknown  <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            idx <= 2'd0;
            if (!lut_known) begin
              // sticky error is kept downstream
              cmd_unknown <= 1'b1;
            end else begin
              action.cmd <= cmd_e'(rx_byte);
              n_params   <= lut_params;
              if (lut_params == 2'd0) begin
                action.valid <= 1'b1;
              end else begin
                state <= read_params;
              end
            end
          end
          read_params: begin
            action.params[idx] <= rx_byte;
            idx                <= idx + 2'd1;
            // last parameter fires the action
            if (idx == n_params - 2'd1) begin
              action.valid <= 1'b1;
              state        <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // one strobe per command, even with back-to-back bytes
  assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    action.valid |=> !action.valid);

endmodule

// File: rtl/esp_link_pkg.sv
package esp_link_pkg;

  // command codes as sent by the co-processor
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    ptrs_rst         = 8'd20,
    z80_pause        = 8'd21,
    z80_resume       = 8'd22,
    set_led          = 8'd26,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32
  } cmd_e;

  // longest parameter list of any command
  localparam int MAX_PARAMS = 3;

  // one complete command, params[0] is the first byte received
  typedef struct packed {
    logic                         valid;
    cmd_e                         cmd;
    logic [MAX_PARAMS-1:0][7:0]   params;
  } cmd_action_t;

  // reply constants
  localparam logic [7:0] COOKIE        = 8'hAF;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // flash transfer timing
  localparam int FLASH_BIT_CYCLES  = 16;
  localparam int FLASH_XFER_CYCLES = 128;
  localparam int FLASH_CNT_W       = $clog2(FLASH_XFER_CYCLES);
  // counter bit that forms the flash sck
  localparam int FLASH_SCK_BIT     = $clog2(FLASH_BIT_CYCLES) - 1;

  // z80 reset pulse
  localparam int Z80_RST_CYCLES = 15;
  localparam int Z80_RST_CNT_W  = $clog2(Z80_RST_CYCLES + 1);

  localparam logic [23:0] SCREEN_COLOR_RESET = 24'hFFFFFF;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

  // configuration flash pins
  typedef struct packed {
    logic cs_n;
    logic sck;
    logic si;
  } flash_pins_t;

endpackage

// File: rtl/esp_link_top.sv
module esp_link_top (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      cs_n,
  input  logic                      sck,
  input  logic                      mosi,
  input  logic                      flash_so,
  output logic                      miso,
  output esp_link_pkg::flash_pins_t flash_pins,
  output esp_link_pkg::led_t        led,
  output byte                       esp_status,
  output logic [23:0]               screen_rgb,
  output logic                      z80_paused,
  output logic                      z80_rst,
  output logic                      cmd_error
);

  import esp_link_pkg::*;

  byte         rx_byte;
  byte         tx_byte;
  byte         flash_rx_byte;
  logic        byte_valid;
  logic        cmd_unknown;
  cmd_action_t action;

  // byte link to the co-processor
  spi_byte_slave u_spi (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_n           (cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .tx_byte        (tx_byte),
    .miso           (miso),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid)
  );

  cmd_parser u_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_valid     (byte_valid),
    .rx_byte        (rx_byte),
    .action         (action),
    .cmd_unknown    (cmd_unknown)
  );

  host_regs u_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .cmd_unknown    (cmd_unknown),
    .flash_rx_byte  (flash_rx_byte),
    .tx_byte        (tx_byte),
    .led            (led),
    .esp_status     (esp_status),
    .screen_rgb     (screen_rgb),
    .z80_paused     (z80_paused),
    .z80_rst        (z80_rst),
    .cmd_error      (cmd_error)
  );

  // configuration flash port
  flash_spi_master u_flash (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .flash_so       (flash_so),
    .flash_pins     (flash_pins),
    .flash_rx_byte  (flash_rx_byte)
  );

endmodule

// File: rtl/flash_spi_master.sv
module flash_spi_master (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  esp_link_pkg::cmd_action_t action,
  input  logic                      flash_so,
  output esp_link_pkg::flash_pins_t flash_pins,
  output byte                       flash_rx_byte
);

  import esp_link_pkg::*;

  // bit 7 of the control register selects the flash
  logic                   ctrl_cs;
  logic                   busy;
  logic [FLASH_CNT_W-1:0] xfer_cnt;
  logic [FLASH_SCK_BIT:0] phase;
  logic [7:0]             shift_reg;
  logic                   si_q;
  logic                   start;

  assign start = action.valid && action.cmd == set_spi_data && !busy;
  assign phase = xfer_cnt[FLASH_SCK_BIT:0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_cs  <= 1'b0;
      busy     <= 1'b0;
      xfer_cnt <= '0;
      si_q     <= 1'b0;
    end else begin
      if (action.valid && action.cmd == set_spi_ctrl_reg) begin
        ctrl_cs <= action.params[0][7];
      end

      if (start) begin
        busy     <= 1'b1;
        xfer_cnt <= '0;
      end else if (busy) begin
        xfer_cnt <= xfer_cnt + 1'b1;
        if (xfer_cnt == FLASH_CNT_W'(FLASH_XFER_CYCLES - 1)) begin
          busy <= 1'b0;
        end
        // next bit goes out as sck falls
        if (phase == '0) begin
          si_q <= shift_reg[7];
        end
      end
    end
  end

  // data shifter, result held until the next transfer
  always_ff @(posedge clk) begin
    if (start) begin
      shift_reg <= action.params[0];
    end else if (busy && phase == (FLASH_SCK_BIT + 1)'(FLASH_BIT_CYCLES / 2)) begin
      shift_reg <= {shift_reg[6:0], flash_so};
    end
  end

  assign flash_pins.cs_n = ~ctrl_cs;
  assign flash_pins.sck  = xfer_cnt[FLASH_SCK_BIT];
  assign flash_pins.si   = si_q;
  assign flash_rx_byte   = shift_reg;

  // counter wraps back to zero as a transfer ends
  assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    !busy |-> !flash_pins.sck);

endmodule

// File: rtl/host_regs.sv
module host_regs (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  esp_link_pkg::cmd_action_t action,
  input  logic                      cmd_unknown,
  input  byte                       flash_rx_byte,
  output byte                       tx_byte,
  output esp_link_pkg::led_t        led,
  output byte                       esp_status,
  output logic [23:0]               screen_rgb,
  output logic                      z80_paused,
  output logic                      z80_rst,
  output logic                      cmd_error
);

  import esp_link_pkg::*;

  logic [Z80_RST_CNT_W-1:0] rst_cnt;

  logic do_cmd;
  assign do_cmd = action.valid;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led        <= '0;
      esp_status <= 8'd0;
      screen_rgb <= SCREEN_COLOR_RESET;
      z80_paused <= 1'b1;
      rst_cnt    <= '0;
      cmd_error  <= 1'b0;
    end else begin
      if (cmd_unknown) begin
        cmd_error <= 1'b1;
      end

      // reset pulse counts down to zero
      if (do_cmd && action.cmd == ptrs_rst) begin
        rst_cnt <= Z80_RST_CNT_W'(Z80_RST_CYCLES);
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end

      if (do_cmd) begin
        case (action.cmd)
          set_led: begin
            led.red   <= action.params[0][0];
            led.green <= action.params[0][1];
            led.blue  <= action.params[0][2];
          end
          set_esp_status: esp_status <= action.params[0];
          // first byte lands in the top byte
          set_screen_color: screen_rgb <= {action.params[0], action.params[1],
                                           action.params[2]};
          z80_pause: z80_paused <= 1'b1;
          z80_resume,
          ptrs_rst: z80_paused <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  assign z80_rst = (rst_cnt != '0);

  // reply register, read out during the next SPI byte
  always_ff @(posedge clk) begin
    if (do_cmd) begin
      case (action.cmd)
        get_cookie:   tx_byte <= COOKIE;
        get_version:  tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
        get_spi_data: tx_byte <= flash_rx_byte;
        default: ;
      endcase
    end
  end

  // a running z80 reset pulse never meets a paused z80
  assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    z80_rst |-> !z80_paused);

endmodule

// File: rtl/spi_byte_slave.sv
module spi_byte_slave (
  input  logic clk,
  input  logic cass_out_sel_n,
  input  logic cs_n,
  input  logic sck,
  input  logic mosi,
  input  byte  tx_byte,
  output logic miso,
  output byte  rx_byte,
  output logic byte_valid
);

  // pin synchronizers
  logic [2:0] sck_sync;
  logic [2:0] cs_n_sync;
  logic [1:0] mosi_sync;

  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] tx_shift;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_n_sync <= 3'b111;
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_n_sync <= {cs_n_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_n_sync[2];

  // bit counter and receive side
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        // eighth bit completes the byte
        if (bit_cnt == 3'd7) begin
          byte_valid <= 1'b1;
        end
      end
    end
  end

  // receive shift register, MSB first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
    end
  end

  // reply shifter, loaded on the first falling edge of a byte
  always_ff @(posedge clk) begin
    if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd1) begin
        tx_shift <= tx_byte;
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'bz;

  // bytes take at least 8 sck edges, so strobes never touch
  assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    byte_valid |=> !byte_valid);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the esp_link testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module esp_link_tb -f esp_link.f -o esp_link_sim \
  && ./obj_dir/esp_link_sim | tee /dev/stderr \
  | grep -F '*** TEST PASSED ***' > /dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: verif/esp_link_tb.sv
module esp_link_tb;

  import esp_link_pkg::*;

  localparam int HALF_SCK    = 8;
  localparam int BYTE_GAP    = 16;
  localparam int CYCLE_LIMIT = 20000;

  logic        clk;
  logic        cass_out_sel_n;
  logic        cs_n;
  logic        sck;
  logic        mosi;
  logic        flash_so;
  wire         miso;
  flash_pins_t flash_pins;
  led_t        led;
  logic [7:0]  esp_status;
  logic [23:0] screen_rgb;
  logic        z80_paused;
  logic        z80_rst;
  logic        cmd_error;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycles = 0;
  int unsigned rst_high_total = 0;
  int          seed = 32'h9411df12;

  // led bits written by the last set_led
  logic [2:0]  last_led = 3'd0;

  // flash device model
  logic [7:0]  flash_resp = 8'h00;
  logic [7:0]  flash_si_seen = 8'h00;
  logic [2:0]  flash_bit = 3'd0;
  logic        flash_sck_q = 1'b0;
  int unsigned flash_falls = 0;

  esp_link_top dut0 (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_n           (cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .flash_so       (flash_so),
    .miso           (miso),
    .flash_pins     (flash_pins),
    .led            (led),
    .esp_status     (esp_status),
    .screen_rgb     (screen_rgb),
    .z80_paused     (z80_paused),
    .z80_rst        (z80_rst),
    .cmd_error      (cmd_error)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // z80 reset pulse length monitor
  always @(negedge clk) begin
    if (z80_rst) begin
      rst_high_total++;
    end
  end

  // next response bit goes out after each falling flash sck
  assign flash_so = flash_resp[3'd7 - flash_bit];

  always @(negedge clk) begin
    flash_sck_q <= flash_pins.sck;
    if (flash_pins.sck && !flash_sck_q) begin
      flash_si_seen <= {flash_si_seen[6:0], flash_pins.si};
    end
    if (!flash_pins.sck && flash_sck_q) begin
      flash_bit   <= flash_bit + 3'd1;
      flash_falls <= flash_falls + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // one byte, MSB first on both lines
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    mosi = tx[7];
    repeat (HALF_SCK) @(negedge clk);
    for (i = 7; i >= 0; i--) begin
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b0;
      if (i > 0) begin
        mosi = tx[i-1];
      end
      repeat (HALF_SCK) @(negedge clk);
      // reply bit settles after the falling edge, read before the next rise
      rx[i] = miso;
    end
    repeat (BYTE_GAP) @(negedge clk);
  endtask

  task automatic frame_begin();
    cs_n = 1'b0;
    repeat (HALF_SCK) @(negedge clk);
  endtask

  task automatic frame_end();
    cs_n = 1'b1;
    repeat (BYTE_GAP) @(negedge clk);
  endtask

  // params holds param 0 in the top byte
  task automatic send_cmd(input logic [7:0] code, input int n_params,
                          input logic [23:0] params);
    logic [7:0] rx;
    int         k;
    frame_begin();
    spi_byte(code, rx);
    for (k = 0; k < n_params; k++) begin
      spi_byte(params[23-8*k -: 8], rx);
    end
    frame_end();
  endtask

  task automatic query(input logic [7:0] code, output logic [7:0] reply);
    logic [7:0] rx;
    frame_begin();
    spi_byte(code, rx);
    spi_byte(8'h00, reply);
    frame_end();
  endtask

  task automatic test_reset_and_ids();
    logic [7:0] reply;
    check_value("reset led", 32'd0, 32'(led));
    check_value("reset esp_status", 32'd0, 32'(esp_status));
    check_value("reset screen_rgb", 32'hFFFFFF, 32'(screen_rgb));
    check_value("reset z80_paused", 32'd1, 32'(z80_paused));
    check_value("reset cmd_error", 32'd0, 32'(cmd_error));
    check_value("reset flash cs_n", 32'd1, 32'(flash_pins.cs_n));
    query(get_cookie, reply);
    check_value("get_cookie", 32'hAF, 32'(reply));
    query(get_version, reply);
    check_value("get_version", 32'h03, 32'(reply));
  endtask

  task automatic test_register_writes();
    logic [7:0]  b;
    logic [23:0] rgb;
    b = 8'($random(seed));
    // led has to move away from its current value
    if (b[2:0] == last_led) begin
      b[2:0] = ~last_led;
    end
    send_cmd(set_led, 1, {b, 16'h0});
    // red follows bit 0 of the parameter
    check_value("set_led", 32'(b[2:0]), 32'({led.blue, led.green, led.red}));
    last_led = b[2:0];
    b = 8'($random(seed));
    send_cmd(set_esp_status, 1, {b, 16'h0});
    check_value("set_esp_status", 32'(b), 32'(esp_status));
    rgb = 24'($random(seed));
    send_cmd(set_screen_color, 3, rgb);
    check_value("set_screen_color", 32'(rgb), 32'(screen_rgb));
  endtask

  task automatic test_flash_transfer();
    logic [7:0]  data;
    logic [7:0]  reply;
    int unsigned falls_start;
    send_cmd(set_spi_ctrl_reg, 1, 24'h800000);
    check_value("flash select", 32'd0, 32'(flash_pins.cs_n));
    data        = 8'($random(seed));
    flash_resp  = 8'($random(seed));
    falls_start = flash_falls;
    send_cmd(set_spi_data, 1, {data, 16'h0});
    // eight falling sck edges end the transfer
    while (flash_falls - falls_start < 8) begin
      @(negedge clk);
    end
    check_value("flash si byte", 32'(data), 32'(flash_si_seen));
    query(get_spi_data, reply);
    check_value("get_spi_data", 32'(flash_resp), 32'(reply));
    send_cmd(set_spi_ctrl_reg, 1, 24'h000000);
    check_value("flash deselect", 32'd1, 32'(flash_pins.cs_n));
  endtask

  task automatic test_z80_control();
    int unsigned rst_start;
    send_cmd(z80_resume, 0, 24'h0);
    check_value("z80_resume", 32'd0, 32'(z80_paused));
    send_cmd(z80_pause, 0, 24'h0);
    check_value("z80_pause", 32'd1, 32'(z80_paused));
    rst_start = rst_high_total;
    send_cmd(ptrs_rst, 0, 24'h0);
    check_value("ptrs_rst pulse cycles", 32'(Z80_RST_CYCLES), rst_high_total - rst_start);
    check_value("ptrs_rst released", 32'd0, 32'(z80_rst));
    check_value("ptrs_rst z80_paused", 32'd0, 32'(z80_paused));
  endtask

  task automatic test_unknown_cmd();
    logic [7:0] b;
    check_value("cmd_error clear", 32'd0, 32'(cmd_error));
    send_cmd(8'hEE, 0, 24'h0);
    check_value("unknown cmd_error", 32'd1, 32'(cmd_error));
    b = 8'($random(seed));
    if (b[2:0] == last_led) begin
      b[2:0] = ~last_led;
    end
    send_cmd(set_led, 1, {b, 16'h0});
    check_value("set_led after unknown", 32'(b[2:0]), 32'({led.blue, led.green, led.red}));
    last_led = b[2:0];
    check_value("cmd_error sticky", 32'd1, 32'(cmd_error));
  endtask

  initial begin
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    cs_n           = 1'b1;
    sck            = 1'b0;
    mosi           = 1'b0;
    repeat (2) @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (4) @(negedge clk);
    test_reset_and_ids();
    test_register_writes();
    test_flash_transfer();
    test_z80_control();
    test_unknown_cmd();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
